// File: rtl/md_pkg.sv
package md_pkg;

	// Operand and result word width.
	localparam int MD_WIDTH = 32;

	// Width of the latency counter, enough for 1 to 15 cycles.
	localparam int MD_CTR_W = 4;

	// Default latencies in clock cycles.
	localparam int unsigned MD_MULT_CYCLES_DEF = 5;
	localparam int unsigned MD_DIV_CYCLES_DEF  = 10;

	// Operation codes presented on op_i.
	typedef enum logic [3:0] {
		MD_NONE  = 4'd0,
		MD_MTHI  = 4'd1,
		MD_MTLO  = 4'd2,
		MD_MULT  = 4'd3,
		MD_MULTU = 4'd4,
		MD_DIV   = 4'd5,
		MD_DIVU  = 4'd6
	} md_op_t;

endpackage

// File: rtl/md_timer.sv
`timescale 1ns/1ps

module md_timer (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        start_i,
	input  logic [md_pkg::MD_CTR_W-1:0] load_val_i,
	input  logic                        hold_i,
	input  logic                        abort_i,
	output logic                        done_o,
	output logic                        running_o
);

	import md_pkg::*;

	logic [MD_CTR_W-1:0] cnt_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (abort_i) begin
			cnt_q <= '0;
		end else if (start_i) begin
			cnt_q <= load_val_i;
		end else if (!hold_i && (cnt_q != '0)) begin
			cnt_q <= cnt_q - MD_CTR_W'(1);
		end
	end

	// Last counting cycle, unless frozen by a stall.
	assign done_o    = (cnt_q == MD_CTR_W'(1)) && !hold_i;
	assign running_o = (cnt_q != '0);

endmodule

// File: rtl/md_arith.sv
`timescale 1ns/1ps

module md_arith (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        capture_i,
	input  md_pkg::md_op_t              op_i,
	input  logic [md_pkg::MD_WIDTH-1:0] dh_i,
	input  logic [md_pkg::MD_WIDTH-1:0] dl_i,
	output logic [md_pkg::MD_WIDTH-1:0] res_hi_o,
	output logic [md_pkg::MD_WIDTH-1:0] res_lo_o,
	output logic                        div_zero_o
);

	import md_pkg::*;

	md_op_t                op_q;
	logic [MD_WIDTH-1:0]   dh_q;
	logic [MD_WIDTH-1:0]   dl_q;
	logic                  is_div;
	logic [MD_WIDTH-1:0]   divisor;
	logic signed [2*MD_WIDTH-1:0] prod_s;
	logic [2*MD_WIDTH-1:0] prod_u;
	logic signed [MD_WIDTH-1:0] quo_s;
	logic signed [MD_WIDTH-1:0] rem_s;
	logic [MD_WIDTH-1:0]   quo_u;
	logic [MD_WIDTH-1:0]   rem_u;
	logic [2*MD_WIDTH-1:0] result;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			op_q <= MD_NONE;
		end else if (capture_i) begin
			op_q <= op_i;
		end
	end

	always_ff @(posedge clk) begin
		if (capture_i) begin
			dh_q <= dh_i;
			dl_q <= dl_i;
		end
	end

	assign is_div     = (op_q == MD_DIV) || (op_q == MD_DIVU);
	assign div_zero_o = is_div && (dl_q == '0);

	// Keeps the divider away from a zero divisor; that result is never written.
	assign divisor = (dl_q == '0) ? MD_WIDTH'(1) : dl_q;

	assign prod_s = $signed({{MD_WIDTH{dh_q[MD_WIDTH-1]}}, dh_q}) *
		$signed({{MD_WIDTH{dl_q[MD_WIDTH-1]}}, dl_q});
	assign prod_u = {{MD_WIDTH{1'b0}}, dh_q} * {{MD_WIDTH{1'b0}}, dl_q};

	// Signed divide truncates toward zero, remainder takes the dividend sign.
	assign quo_s = $signed(dh_q) / $signed(divisor);
	assign rem_s = $signed(dh_q) % $signed(divisor);
	assign quo_u = dh_q / divisor;
	assign rem_u = dh_q % divisor;

	always_comb begin
		case (op_q)
			MD_MULT:  result = prod_s;
			MD_MULTU: result = prod_u;
			MD_DIV:   result = {rem_s, quo_s};
			MD_DIVU:  result = {rem_u, quo_u};
			default:  result = '0;
		endcase
	end

	assign res_hi_o = result[2*MD_WIDTH-1:MD_WIDTH];
	assign res_lo_o = result[MD_WIDTH-1:0];

endmodule

// File: rtl/md_hilo.sv
`timescale 1ns/1ps

module md_hilo (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        wr_res_i,
	input  logic                        wr_hi_i,
	input  logic                        wr_lo_i,
	input  logic                        restore_i,
	input  logic [md_pkg::MD_WIDTH-1:0] res_hi_i,
	input  logic [md_pkg::MD_WIDTH-1:0] res_lo_i,
	input  logic [md_pkg::MD_WIDTH-1:0] dh_i,
	output logic [md_pkg::MD_WIDTH-1:0] hi_o,
	output logic [md_pkg::MD_WIDTH-1:0] lo_o
);

	import md_pkg::*;

	logic [MD_WIDTH-1:0] hi_q;
	logic [MD_WIDTH-1:0] lo_q;
	logic [MD_WIDTH-1:0] bak_hi_q;
	logic [MD_WIDTH-1:0] bak_lo_q;
	logic                any_wr;

	assign any_wr = wr_res_i || wr_hi_i || wr_lo_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hi_q     <= '0;
			lo_q     <= '0;
			bak_hi_q <= '0;
			bak_lo_q <= '0;
		end else if (restore_i) begin
			// Backup stays as is, so a second restore lands on the same pair.
			hi_q <= bak_hi_q;
			lo_q <= bak_lo_q;
		end else if (any_wr) begin
			bak_hi_q <= hi_q;
			bak_lo_q <= lo_q;
			if (wr_res_i) begin
				hi_q <= res_hi_i;
				lo_q <= res_lo_i;
			end else if (wr_hi_i) begin
				hi_q <= dh_i;
			end else begin
				lo_q <= dh_i;
			end
		end
	end

	assign hi_o = hi_q;
	assign lo_o = lo_q;

endmodule

// File: rtl/md_ctrl.sv
`timescale 1ns/1ps

module md_ctrl #(
	parameter int unsigned MULT_CYCLES = md_pkg::MD_MULT_CYCLES_DEF,
	parameter int unsigned DIV_CYCLES  = md_pkg::MD_DIV_CYCLES_DEF
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  md_pkg::md_op_t              op_i,
	input  logic                        stop_i,
	input  logic                        restore_i,
	input  logic                        done_i,
	input  logic                        running_i,
	input  logic                        div_zero_i,
	output logic                        start_o,
	output logic [md_pkg::MD_CTR_W-1:0] load_val_o,
	output logic                        hold_o,
	output logic                        abort_o,
	output logic                        capture_o,
	output logic                        wr_res_o,
	output logic                        wr_hi_o,
	output logic                        wr_lo_o,
	output logic                        restore_o,
	output logic                        busy_o,
	output logic                        invalid_o
);

	import md_pkg::*;

	typedef enum logic {
		IDLE = 1'b0,
		RUN  = 1'b1
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   is_mul;
	logic   is_div;
	logic   accept;
	logic   invalid_q;

	assign is_mul = (op_i == MD_MULT) || (op_i == MD_MULTU);
	assign is_div = (op_i == MD_DIV) || (op_i == MD_DIVU);

	// An issue only counts in IDLE and when neither stop nor restore is up.
	assign accept = (state_q == IDLE) && (op_i != MD_NONE) && !stop_i && !restore_i;

	assign capture_o  = accept && (is_mul || is_div);
	assign start_o    = capture_o;
	assign load_val_o = is_div ? MD_CTR_W'(DIV_CYCLES) : MD_CTR_W'(MULT_CYCLES);

	assign wr_hi_o = accept && (op_i == MD_MTHI);
	assign wr_lo_o = accept && (op_i == MD_MTLO);

	// Result is dropped for a divide by zero or when restore arrives with it.
	assign wr_res_o = (state_q == RUN) && done_i && !div_zero_i && !restore_i;

	assign hold_o    = stop_i;
	assign abort_o   = restore_i;
	assign restore_o = restore_i;

	assign busy_o    = running_i;
	assign invalid_o = invalid_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (capture_o) begin
					state_d = RUN;
				end
			end
			RUN: begin
				if (restore_i || done_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q   <= IDLE;
			invalid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Flag follows the captured operands one edge later.
			if (accept) begin
				invalid_q <= 1'b0;
			end else if (state_q == RUN) begin
				invalid_q <= div_zero_i;
			end
		end
	end

endmodule

// File: rtl/md_unit.sv
`timescale 1ns/1ps

module md_unit #(
	parameter int unsigned MULT_CYCLES = md_pkg::MD_MULT_CYCLES_DEF,
	parameter int unsigned DIV_CYCLES  = md_pkg::MD_DIV_CYCLES_DEF
) (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  md_pkg::md_op_t              op_i,
	input  logic [md_pkg::MD_WIDTH-1:0] dh_i,
	input  logic [md_pkg::MD_WIDTH-1:0] dl_i,
	input  logic                        stop_i,
	input  logic                        restore_i,
	output logic                        busy_o,
	output logic                        invalid_o,
	output logic [md_pkg::MD_WIDTH-1:0] hi_o,
	output logic [md_pkg::MD_WIDTH-1:0] lo_o
);

	import md_pkg::*;

	logic                start;
	logic [MD_CTR_W-1:0] load_val;
	logic                hold;
	logic                abort;
	logic                done;
	logic                running;
	logic                capture;
	logic                div_zero;
	logic                wr_res;
	logic                wr_hi;
	logic                wr_lo;
	logic                restore;
	logic [MD_WIDTH-1:0] res_hi;
	logic [MD_WIDTH-1:0] res_lo;

	md_ctrl #(
		.MULT_CYCLES (MULT_CYCLES),
		.DIV_CYCLES  (DIV_CYCLES)
	) i_ctrl (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.op_i       (op_i),
		.stop_i     (stop_i),
		.restore_i  (restore_i),
		.done_i     (done),
		.running_i  (running),
		.div_zero_i (div_zero),
		.start_o    (start),
		.load_val_o (load_val),
		.hold_o     (hold),
		.abort_o    (abort),
		.capture_o  (capture),
		.wr_res_o   (wr_res),
		.wr_hi_o    (wr_hi),
		.wr_lo_o    (wr_lo),
		.restore_o  (restore),
		.busy_o     (busy_o),
		.invalid_o  (invalid_o)
	);

	md_timer i_timer (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.start_i    (start),
		.load_val_i (load_val),
		.hold_i     (hold),
		.abort_i    (abort),
		.done_o     (done),
		.running_o  (running)
	);

	md_arith i_arith (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.capture_i  (capture),
		.op_i       (op_i),
		.dh_i       (dh_i),
		.dl_i       (dl_i),
		.res_hi_o   (res_hi),
		.res_lo_o   (res_lo),
		.div_zero_o (div_zero)
	);

	md_hilo i_hilo (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.wr_res_i  (wr_res),
		.wr_hi_i   (wr_hi),
		.wr_lo_i   (wr_lo),
		.restore_i (restore),
		.res_hi_i  (res_hi),
		.res_lo_i  (res_lo),
		.dh_i      (dh_i),
		.hi_o      (hi_o),
		.lo_o      (lo_o)
	);

endmodule

// File: dv/tb_md_unit.sv
`timescale 1ns/1ps

module tb_md_unit;

	import md_pkg::*;

	localparam int unsigned MULT_CYCLES = MD_MULT_CYCLES_DEF;
	localparam int unsigned DIV_CYCLES  = MD_DIV_CYCLES_DEF;
	localparam int CASE_WORDS = 8;
	localparam int MAX_CASES  = 64;

	logic                clk;
	logic                rst_n_i;
	md_op_t              op_i;
	logic [MD_WIDTH-1:0] dh_i;
	logic [MD_WIDTH-1:0] dl_i;
	logic                stop_i;
	logic                restore_i;
	logic                busy_o;
	logic                invalid_o;
	logic [MD_WIDTH-1:0] hi_o;
	logic [MD_WIDTH-1:0] lo_o;

	logic [31:0]         case_mem [0:CASE_WORDS*MAX_CASES-1];
	int                  num_cases;
	int                  max_stall;
	int                  cycle_cnt;
	int                  cycle_limit;
	int                  seed;
	int                  n_pass;
	int                  n_fail;
	// Expected HI and LO as they stand between cases.
	logic [MD_WIDTH-1:0] model_hi;
	logic [MD_WIDTH-1:0] model_lo;

	md_unit #(
		.MULT_CYCLES (MULT_CYCLES),
		.DIV_CYCLES  (DIV_CYCLES)
	) i_dut (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.op_i      (op_i),
		.dh_i      (dh_i),
		.dl_i      (dl_i),
		.stop_i    (stop_i),
		.restore_i (restore_i),
		.busy_o    (busy_o),
		.invalid_o (invalid_o),
		.hi_o      (hi_o),
		.lo_o      (lo_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic run_case(input int idx);
		md_op_t              op;
		logic [MD_WIDTH-1:0] dh;
		logic [MD_WIDTH-1:0] dl;
		int                  stall;
		logic                do_restore;
		logic [MD_WIDTH-1:0] exp_hi;
		logic [MD_WIDTH-1:0] exp_lo;
		logic                exp_inv;
		int                  exp_busy;
		int                  busy_cnt;
		int                  stall_left;
		int                  gap;
		int                  errs;
		int                  base;
		base       = idx * CASE_WORDS;
		op         = md_op_t'(case_mem[base][3:0]);
		dh         = case_mem[base+1];
		dl         = case_mem[base+2];
		stall      = case_mem[base+3];
		do_restore = case_mem[base+4][0];
		exp_hi     = case_mem[base+5];
		exp_lo     = case_mem[base+6];
		exp_inv    = case_mem[base+7][0];
		errs       = 0;

		// Moves never raise busy, the others add every stalled cycle.
		if (op == MD_MULT || op == MD_MULTU) begin
			exp_busy = MULT_CYCLES + stall;
		end else if (op == MD_DIV || op == MD_DIVU) begin
			exp_busy = DIV_CYCLES + stall;
		end else begin
			exp_busy = 0;
		end

		gap = 1 + int'($unsigned($random(seed)) % 3);
		repeat (gap) @(negedge clk);
		op_i = op;
		dh_i = dh;
		dl_i = dl;
		@(negedge clk);
		// Operands change right after issue, the unit must hold its own copy.
		op_i = MD_NONE;
		dh_i = ~dh;
		dl_i = ~dl;
		busy_cnt   = 0;
		stall_left = stall;
		while (busy_o) begin
			busy_cnt++;
			stop_i = (stall_left != 0);
			if (stall_left != 0) begin
				stall_left--;
			end
			@(negedge clk);
		end
		stop_i = 1'b0;

		if (busy_cnt != exp_busy) begin
			$display("CHECK FAILED busy_o cycles expected %h got %h", exp_busy, busy_cnt);
			errs++;
		end
		if (hi_o !== exp_hi) begin
			$display("CHECK FAILED hi_o expected %h got %h", exp_hi, hi_o);
			errs++;
		end
		if (lo_o !== exp_lo) begin
			$display("CHECK FAILED lo_o expected %h got %h", exp_lo, lo_o);
			errs++;
		end
		if (invalid_o !== exp_inv) begin
			$display("CHECK FAILED invalid_o expected %h got %h", exp_inv, invalid_o);
			errs++;
		end

		if (do_restore) begin
			restore_i = 1'b1;
			@(negedge clk);
			restore_i = 1'b0;
			if (hi_o !== model_hi) begin
				$display("CHECK FAILED hi_o after restore expected %h got %h", model_hi, hi_o);
				errs++;
			end
			if (lo_o !== model_lo) begin
				$display("CHECK FAILED lo_o after restore expected %h got %h", model_lo, lo_o);
				errs++;
			end
		end else begin
			model_hi = exp_hi;
			model_lo = exp_lo;
		end

		if (errs == 0) begin
			n_pass++;
			$display("case %0d %s: ok", idx, op.name());
		end else begin
			n_fail++;
			$display("case %0d %s: %0d mismatches", idx, op.name(), errs);
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst_n_i   = 1'b0;
		op_i      = MD_NONE;
		dh_i      = '0;
		dl_i      = '0;
		stop_i    = 1'b0;
		restore_i = 1'b0;
		seed      = 32'h31f7;
		cycle_cnt = 0;
		n_pass    = 0;
		n_fail    = 0;
		model_hi  = '0;
		model_lo  = '0;

		for (int i = 0; i < CASE_WORDS*MAX_CASES; i++) begin
			case_mem[i] = '0;
		end
		$readmemh("dv/md_cases.mem", case_mem);

		// The list ends at the first line whose op is MD_NONE.
		num_cases = 0;
		max_stall = 0;
		while (num_cases < MAX_CASES && case_mem[num_cases*CASE_WORDS] != 0) begin
			if (int'(case_mem[num_cases*CASE_WORDS+3]) > max_stall) begin
				max_stall = case_mem[num_cases*CASE_WORDS+3];
			end
			num_cases++;
		end
		cycle_limit = num_cases * (DIV_CYCLES + max_stall + 8) + 20;
		if (num_cases == 0) begin
			$display("No test cases were found in dv/md_cases.mem");
			n_fail++;
		end

		repeat (5) @(negedge clk);
		rst_n_i = 1'b1;

		for (int c = 0; c < num_cases; c++) begin
			run_case(c);
		end

		$display("cases %0d, passed %0d, failed %0d", num_cases, n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: dv/md_cases.mem
// op dh dl stall restore exp_hi exp_lo exp_invalid, all hex
// op: 1 MTHI, 2 MTLO, 3 MULT, 4 MULTU, 5 DIV, 6 DIVU
1 12345678 00000000 0 0 12345678 00000000 0
2 9abcdef0 00000000 0 0 12345678 9abcdef0 0
1 deadbeef 00000000 0 1 deadbeef 9abcdef0 0
4 00000007 00000006 0 0 00000000 0000002a 0
3 ffffffff 00000005 2 0 ffffffff fffffffb 0
4 ffffffff ffffffff 0 0 fffffffe 00000001 0
3 7fffffff 7fffffff 1 0 3fffffff 00000001 0
3 80000000 80000000 0 0 40000000 00000000 0
3 80000000 7fffffff 3 1 c0000000 80000000 0
3 fffffffd 00001000 0 0 ffffffff ffffd000 0
6 00000064 00000007 0 0 00000002 0000000e 0
5 ffffff9c 00000007 2 0 fffffffe fffffff2 0
5 00000064 fffffff9 0 0 00000002 fffffff2 0
5 ffffff9c fffffff9 1 0 fffffffe 0000000e 0
6 ffffff9c 00000007 0 0 00000002 24924916 0
6 0000000a 00000000 0 0 00000002 24924916 1
5 80000000 00000000 2 0 00000002 24924916 1
5 80000000 00000002 0 0 00000000 c0000000 0
2 0000abcd 00000000 0 0 00000000 0000abcd 0
4 00010000 00010000 1 1 00000001 00000000 0
6 0000abcd 00000010 0 0 0000000d 00000abc 0

// File: verilog.f
rtl/md_pkg.sv
rtl/md_timer.sv
rtl/md_arith.sv
rtl/md_hilo.sv
rtl/md_ctrl.sv
rtl/md_unit.sv
dv/tb_md_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_md_unit -f verilog.f -o sim_md_unit || exit 1
out="$(./obj_dir/sim_md_unit)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
